/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_silver
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/10ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/reg_file.sv */
//////////////////////////////////////////////////
// Register file, 64 x 32
// three read ports, one write port, write-through
//////////////////////////////////////////////////

`timescale 1ns/10ps

module reg_file (
   input  logic                  clk,
   input  logic                  reset,
   input  silver_pkg::reg_addr_t rd_addr_a,
   input  silver_pkg::reg_addr_t rd_addr_b,
   input  silver_pkg::reg_addr_t rd_addr_w,
   output silver_pkg::word_t     rd_data_a,
   output silver_pkg::word_t     rd_data_b,
   output silver_pkg::word_t     rd_data_w,
   input  logic                  wb_en,
   input  silver_pkg::reg_addr_t wb_addr,
   input  silver_pkg::word_t     wb_data
);
   import silver_pkg::*;

   localparam int n_regs = 2 ** $bits(reg_addr_t);

   word_t regs [n_regs];

   // same-cycle write is visible to decode
   function automatic word_t read_port(input reg_addr_t addr);
      if (wb_en && wb_addr == addr)
         return wb_data;
      return regs[addr];
   endfunction

   always_comb begin
      rd_data_a = read_port(rd_addr_a);
      rd_data_b = read_port(rd_addr_b);
      rd_data_w = read_port(rd_addr_w);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < n_regs; i++)
            regs[i] <= '0;
      end else if (wb_en) begin
         regs[wb_addr] <= wb_data;
      end
   end

endmodule

/* hdl/silver_cfg.svh */
//////////////////////////////////////////////////
// Silver core widths
// word, register address, immediate and I/O sizes
//////////////////////////////////////////////////

`ifndef SILVER_CFG_SVH
`define SILVER_CFG_SVH

`define SILVER_WORD_W 32
`define SILVER_REG_AW 6   // 64 registers
`define SILVER_IMM_W  6   // small operand immediate
`define SILVER_OUT_W  10
`define SILVER_IN_W   2

`endif

/* hdl/silver_core.sv */
//////////////////////////////////////////////////
// Silver execution core
// decode, execute and result around the register file
//////////////////////////////////////////////////

`timescale 1ns/10ps
`include "silver_cfg.svh"

module silver_core (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     instr_valid,
   input  silver_pkg::word_t        instr,
   input  logic [`SILVER_IN_W-1:0]  data_in,
   output logic [`SILVER_OUT_W-1:0] data_out
);
   import silver_pkg::*;

   reg_addr_t rd_addr_a;
   reg_addr_t rd_addr_b;
   reg_addr_t rd_addr_w;
   word_t     rd_data_a;
   word_t     rd_data_b;
   word_t     rd_data_w;
   logic      wb_en;
   reg_addr_t wb_addr;
   word_t     wb_data;

   stage_if #(.payload_t(dec_t)) dec_bus ();
   stage_if #(.payload_t(exe_t)) exe_bus ();

   reg_file u_reg_file (
      .clk       (clk),
      .reset     (reset),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_addr_w (rd_addr_w),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .rd_data_w (rd_data_w),
      .wb_en     (wb_en),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data)
   );

   silver_decode u_decode (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .rd_addr_a   (rd_addr_a),
      .rd_addr_b   (rd_addr_b),
      .rd_addr_w   (rd_addr_w),
      .rd_data_a   (rd_data_a),
      .rd_data_b   (rd_data_b),
      .rd_data_w   (rd_data_w),
      .dec         (dec_bus)
   );

   silver_execute u_execute (
      .clk     (clk),
      .reset   (reset),
      .data_in (data_in),
      .dec     (dec_bus),
      .exe     (exe_bus),
      .wb_en   (wb_en),
      .wb_addr (wb_addr),
      .wb_data (wb_data)
   );

   silver_result u_result (
      .clk      (clk),
      .reset    (reset),
      .exe      (exe_bus),
      .wb_en    (wb_en),
      .wb_addr  (wb_addr),
      .wb_data  (wb_data),
      .data_out (data_out)
   );

endmodule

/* hdl/silver_decode.sv */
//////////////////////////////////////////////////
// Silver decode stage
// opcode class, immediates, operand read
//////////////////////////////////////////////////

`timescale 1ns/10ps
`include "silver_cfg.svh"

module silver_decode (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  instr_valid,
   input  silver_pkg::word_t     instr,
   output silver_pkg::reg_addr_t rd_addr_a,
   output silver_pkg::reg_addr_t rd_addr_b,
   output silver_pkg::reg_addr_t rd_addr_w,
   input  silver_pkg::word_t     rd_data_a,
   input  silver_pkg::word_t     rd_data_b,
   input  silver_pkg::word_t     rd_data_w,
   stage_if.producer             dec
);
   import silver_pkg::*;

   localparam int pad_imm = `SILVER_WORD_W - `SILVER_IMM_W;
   localparam int pad_const = `SILVER_WORD_W - 23;
   localparam int pad_upper = `SILVER_WORD_W - 9;

   opc_e  opc;
   word_t imm_a;
   word_t imm_b;
   word_t imm_w;
   word_t const_mag;
   dec_t  dec_next;

   assign rd_addr_a = instr[22:17];
   assign rd_addr_b = instr[15:10];
   assign rd_addr_w = instr[30:25];

   always_comb begin
      opc = op_invalid;
      if (instr[24]) begin
         if (instr[31])
            opc = op_load_const;
         else if (instr[23:9] == '0)
            opc = op_load_upper;
      end else if (!instr[31]) begin
         case (instr[5:0])
            6'd0:    opc = op_normal;
            6'd1:    opc = op_shift;
            6'd6:    opc = op_out;
            6'd7:    opc = op_in;
            default: opc = op_invalid;   // memory, jumps, acc, interrupt
         endcase
      end
   end

   assign imm_a = {{pad_imm{instr[22]}}, instr[22:17]};
   assign imm_b = {{pad_imm{instr[15]}}, instr[15:10]};
   assign imm_w = {{pad_imm{instr[30]}}, instr[30:25]};
   assign const_mag = {{pad_const{1'b0}}, instr[22:0]};

   always_comb begin
      dec_next.opc = opc;
      if (opc == op_normal || opc == op_shift || opc == op_out)
         dec_next.func = alu_func_e'(instr[9:6]);
      else
         dec_next.func = f_and;
      dec_next.a_reg = !instr[23];
      dec_next.b_reg = !instr[16];
      dec_next.w_reg = !instr[31];
      dec_next.a_addr = rd_addr_a;
      dec_next.b_addr = rd_addr_b;
      dec_next.w_addr = rd_addr_w;
      dec_next.a = instr[23] ? imm_a : rd_data_a;
      dec_next.b = instr[16] ? imm_b : rd_data_b;
      dec_next.w = instr[31] ? imm_w : rd_data_w;
      if (opc == op_load_const)
         dec_next.imm = instr[23] ? -const_mag : const_mag;   // bit 23 is the sign
      else if (opc == op_load_upper)
         dec_next.imm = {{pad_upper{1'b0}}, instr[8:0]};
      else
         dec_next.imm = '0;
   end

   always_ff @(posedge clk) begin
      if (reset)
         dec.valid <= 1'b0;
      else
         dec.valid <= instr_valid && (opc != op_invalid);
   end

   always_ff @(posedge clk) begin
      dec.payload <= dec_next;
   end

endmodule

/* hdl/silver_execute.sv */
//////////////////////////////////////////////////
// Silver execute stage
// forwarding, ALU with flags, shifter
//////////////////////////////////////////////////

`timescale 1ns/10ps
`include "silver_cfg.svh"

module silver_execute (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`SILVER_IN_W-1:0] data_in,
   stage_if.consumer               dec,
   stage_if.producer               exe,
   input  logic                    wb_en,
   input  silver_pkg::reg_addr_t   wb_addr,
   input  silver_pkg::word_t       wb_data
);
   import silver_pkg::*;

   localparam int ww = `SILVER_WORD_W;
   localparam int msb = ww - 1;

   word_t                   op_a;
   word_t                   op_b;
   word_t                   op_w;
   alu_func_e               func;
   shift_e                  sh_kind;
   logic [ww:0]             sum;
   word_t                   diff;
   logic [2*ww-1:0]         prod;
   logic                    add_ovf;
   logic                    sub_ovf;
   logic                    flag_en;
   logic                    carry_flag;
   logic                    overflow_flag;
   logic [$clog2(ww)-1:0]   rot;
   word_t                   alu_res;
   word_t                   shift_res;
   exe_t                    exe_next;

   // result stage holds the instruction just ahead of this one
   function automatic word_t fwd(input word_t v, input reg_addr_t addr, input logic is_reg,
                                 input logic en, input reg_addr_t w_addr, input word_t w_data);
      if (is_reg && en && w_addr == addr)
         return w_data;
      return v;
   endfunction

   assign op_a = fwd(dec.payload.a, dec.payload.a_addr, dec.payload.a_reg,
                     wb_en, wb_addr, wb_data);
   assign op_b = fwd(dec.payload.b, dec.payload.b_addr, dec.payload.b_reg,
                     wb_en, wb_addr, wb_data);
   assign op_w = fwd(dec.payload.w, dec.payload.w_addr, dec.payload.w_reg,
                     wb_en, wb_addr, wb_data);

   assign func = dec.payload.func;
   assign sh_kind = shift_e'(func[1:0]);

   assign sum = {1'b0, op_a} + {1'b0, op_b} + {{ww{1'b0}}, (func == f_add_carry) & carry_flag};
   assign diff = op_a - op_b;
   assign prod = {{ww{1'b0}}, op_a} * {{ww{1'b0}}, op_b};
   assign add_ovf = (op_a[msb] == op_b[msb]) && (sum[msb] != op_a[msb]);
   assign sub_ovf = (op_a[msb] != op_b[msb]) && (diff[msb] != op_a[msb]);
   assign rot = op_b[$clog2(ww)-1:0];   // rotate amount mod 32

   always_comb begin
      case (func)
         f_add, f_add_carry: alu_res = sum[msb:0];
         f_sub:      alu_res = diff;
         f_carry:    alu_res = word_t'(carry_flag);
         f_overflow: alu_res = word_t'(overflow_flag);
         f_inc:      alu_res = op_a + word_t'(1);
         f_dec:      alu_res = op_a - word_t'(1);
         f_mul:      alu_res = prod[msb:0];
         f_mulhu:    alu_res = prod[2*ww-1:ww];
         f_and:      alu_res = op_a & op_b;
         f_or:       alu_res = op_a | op_b;
         f_xor:      alu_res = op_a ^ op_b;
         f_equal:    alu_res = word_t'(op_a == op_b);
         f_less:     alu_res = word_t'($signed(op_a) < $signed(op_b));
         f_lower:    alu_res = word_t'(op_a < op_b);
         default:    alu_res = op_b;   // f_snd
      endcase
   end

   always_comb begin
      case (sh_kind)
         sh_ll:   shift_res = op_a << op_b;
         sh_lr:   shift_res = op_a >> op_b;
         sh_ar:   shift_res = word_t'($signed(op_a) >>> op_b);
         default: shift_res = (op_a >> rot) | (op_a << (ww - rot));
      endcase
   end

   assign flag_en = dec.valid && (dec.payload.opc == op_normal || dec.payload.opc == op_out);

   always_ff @(posedge clk) begin
      if (reset) begin
         carry_flag <= 1'b0;
         overflow_flag <= 1'b0;
      end else if (flag_en) begin
         if (func == f_add || func == f_add_carry)
            carry_flag <= sum[ww];
         if (func == f_add)
            overflow_flag <= add_ovf;
         else if (func == f_sub)
            overflow_flag <= sub_ovf;
      end
   end

   always_comb begin
      exe_next.opc = dec.payload.opc;
      exe_next.w_addr = dec.payload.w_addr;
      exe_next.alu_res = alu_res;
      exe_next.shift_res = shift_res;
      exe_next.w_old = op_w;
      exe_next.imm = dec.payload.imm;
      exe_next.din = data_in;
   end

   always_ff @(posedge clk) begin
      if (reset)
         exe.valid <= 1'b0;
      else
         exe.valid <= dec.valid;
   end

   always_ff @(posedge clk) begin
      exe.payload <= exe_next;
   end

endmodule

/* hdl/silver_pkg.sv */
//////////////////////////////////////////////////
// Silver core types
// opcodes, ALU functions and stage payloads
//////////////////////////////////////////////////

`include "silver_cfg.svh"

package silver_pkg;

   typedef logic [`SILVER_WORD_W-1:0] word_t;
   typedef logic [`SILVER_REG_AW-1:0] reg_addr_t;

   // kept opcodes only, everything else decodes to op_invalid
   typedef enum logic [5:0] {
      op_normal     = 6'd0,
      op_shift      = 6'd1,
      op_out        = 6'd6,
      op_in         = 6'd7,
      op_load_const = 6'd13,
      op_load_upper = 6'd14,
      op_invalid    = 6'd15
   } opc_e;

   typedef enum logic [3:0] {
      f_add, f_add_carry, f_sub, f_carry,
      f_overflow, f_inc, f_dec, f_mul,
      f_mulhu, f_and, f_or, f_xor,
      f_equal, f_less, f_lower, f_snd
   } alu_func_e;

   typedef enum logic [1:0] {sh_ll, sh_lr, sh_ar, sh_ror} shift_e;

   typedef struct packed {
      opc_e      opc;
      alu_func_e func;
      word_t     a;
      word_t     b;
      word_t     w;
      reg_addr_t a_addr;
      reg_addr_t b_addr;
      reg_addr_t w_addr;
      logic      a_reg;   // operand came from a register
      logic      b_reg;
      logic      w_reg;
      word_t     imm;     // LoadConstant / LoadUpperConstant value
   } dec_t;

   typedef struct packed {
      opc_e                   opc;
      reg_addr_t              w_addr;
      word_t                  alu_res;
      word_t                  shift_res;
      word_t                  w_old;
      word_t                  imm;
      logic [`SILVER_IN_W-1:0] din;
   } exe_t;

endpackage

/* hdl/silver_result.sv */
//////////////////////////////////////////////////
// Silver result stage
// write-back select and data_out register
//////////////////////////////////////////////////

`timescale 1ns/10ps
`include "silver_cfg.svh"

module silver_result (
   input  logic                     clk,
   input  logic                     reset,
   stage_if.consumer                exe,
   output logic                     wb_en,
   output silver_pkg::reg_addr_t    wb_addr,
   output silver_pkg::word_t        wb_data,
   output logic [`SILVER_OUT_W-1:0] data_out
);
   import silver_pkg::*;

   assign wb_en = exe.valid;   // every kept opcode writes w
   assign wb_addr = exe.payload.w_addr;

   always_comb begin
      case (exe.payload.opc)
         op_shift:      wb_data = exe.payload.shift_res;
         op_in:         wb_data = word_t'(exe.payload.din);
         op_load_const: wb_data = exe.payload.imm;
         op_load_upper: wb_data = {exe.payload.imm[8:0], exe.payload.w_old[22:0]};
         default:       wb_data = exe.payload.alu_res;   // normal, out
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         data_out <= '0;
      else if (exe.valid && exe.payload.opc == op_out)
         data_out <= exe.payload.alu_res[`SILVER_OUT_W-1:0];
   end

endmodule

/* hdl/stage_if.sv */
//////////////////////////////////////////////////
// Pipeline stage link
// valid strobe plus one registered payload
//////////////////////////////////////////////////

`timescale 1ns/10ps

interface stage_if #(
   parameter type payload_t = logic
) ();

   logic     valid;
   payload_t payload;

   modport producer (
      output valid,
      output payload
   );

   modport consumer (
      input valid,
      input payload
   );

endinterface

/* sources.f */
+incdir+hdl
hdl/silver_pkg.sv
hdl/stage_if.sv
hdl/reg_file.sv
hdl/silver_decode.sv
hdl/silver_execute.sv
hdl/silver_result.sv
hdl/silver_core.sv
tests/tb_clock.sv
tests/tb_silver.sv

/* tests/tb_clock.sv */
//////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock #(
   parameter int half_period  = 50,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* tests/tb_silver.sv */
//////////////////////////////////////////////////
// Silver core testbench
// directed tests against a register and flag model
//////////////////////////////////////////////////

`timescale 1ns/10ps
`include "silver_cfg.svh"

module tb_silver;
   import silver_pkg::*;

   logic                     clk;
   logic                     reset;
   logic                     instr_valid;
   logic [31:0]              instr;
   logic [`SILVER_IN_W-1:0]  data_in;
   logic [`SILVER_OUT_W-1:0] data_out;

   logic [31:0]              m_regs [64];
   logic                     m_carry;
   logic                     m_ovf;
   logic [`SILVER_OUT_W-1:0] m_out;
   int                       checks;
   int                       errors;
   logic                     reset_ok;

   tb_clock #(.half_period(50), .reset_cycles(3)) u_clock (.clk(clk), .reset(reset));

   silver_core dut (
      .clk         (clk),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .data_in     (data_in),
      .data_out    (data_out)
   );

   function automatic logic [31:0] encode_alu(input logic [5:0] opc, input logic [3:0] fn,
                                              input logic [5:0] w, input logic [5:0] a,
                                              input logic b_imm, input logic [5:0] b);
      return {1'b0, w, 1'b0, 1'b0, a, b_imm, b, fn, opc};
   endfunction

   function automatic logic [31:0] encode_lc(input logic [5:0] w, input logic neg,
                                             input logic [22:0] mag);
      return {1'b1, w, 1'b1, neg, mag};
   endfunction

   function automatic logic [31:0] encode_lu(input logic [5:0] w, input logic [8:0] c);
      return {1'b0, w, 1'b1, 15'b0, c};
   endfunction

   function automatic logic [31:0] shift_model(input logic [1:0] kind, input logic [31:0] a,
                                               input logic [31:0] amt);
      logic [31:0] r;
      int          n;
      r = a;
      n = int'(amt[4:0]);
      if (kind == 2'd0)
         r = (amt >= 32) ? '0 : a << n;
      else if (kind == 2'd1)
         r = (amt >= 32) ? '0 : a >> n;
      else if (kind == 2'd2 && amt >= 32)
         r = {32{a[31]}};
      else if (kind == 2'd2)
         r = $signed(a) >>> n;
      else
         for (int i = 0; i < n; i++)
            r = {r[0], r[31:1]};   // one bit at a time
      return r;
   endfunction

   // sequential model, one instruction at a time in program order
   task automatic model_exec(input logic [31:0] ins);
      logic [5:0]  wa;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [32:0] s33;
      logic [63:0] prod;
      longint      sres;
      logic        c_new;
      logic        v_new;
      wa = ins[30:25];
      a = ins[23] ? {{26{ins[22]}}, ins[22:17]} : m_regs[ins[22:17]];
      b = ins[16] ? {{26{ins[15]}}, ins[15:10]} : m_regs[ins[15:10]];
      prod = {32'b0, a} * {32'b0, b};
      c_new = m_carry;
      v_new = m_ovf;
      res = b;
      case (ins[9:6])
         f_add, f_add_carry: begin
            s33 = {1'b0, a} + {1'b0, b} + {32'b0, (ins[9:6] == f_add_carry) & m_carry};
            res = s33[31:0];
            c_new = s33[32];
            sres = longint'($signed(a)) + longint'($signed(b));
            if (ins[9:6] == f_add)
               v_new = sres != longint'($signed(res));
         end
         f_sub: begin
            res = a - b;
            sres = longint'($signed(a)) - longint'($signed(b));
            v_new = sres != longint'($signed(res));
         end
         f_carry:    res = {31'b0, m_carry};
         f_overflow: res = {31'b0, m_ovf};
         f_inc:      res = a + 32'd1;
         f_dec:      res = a - 32'd1;
         f_mul:      res = prod[31:0];
         f_mulhu:    res = prod[63:32];
         f_and:      res = a & b;
         f_or:       res = a | b;
         f_xor:      res = a ^ b;
         f_equal:    res = {31'b0, a == b};
         f_less:     res = {31'b0, $signed(a) < $signed(b)};
         f_lower:    res = {31'b0, a < b};
         default:    res = b;
      endcase
      if (ins[24] && ins[31])
         m_regs[wa] = ins[23] ? -{9'b0, ins[22:0]} : {9'b0, ins[22:0]};
      else if (ins[24])
         m_regs[wa] = {ins[8:0], m_regs[wa][22:0]};
      else if (ins[5:0] == 6'd0 || ins[5:0] == 6'd6) begin
         m_regs[wa] = res;
         m_carry = c_new;
         m_ovf = v_new;
         if (ins[5:0] == 6'd6)
            m_out = res[`SILVER_OUT_W-1:0];
      end else if (ins[5:0] == 6'd1)
         m_regs[wa] = shift_model(ins[7:6], a, b);
      else if (ins[5:0] == 6'd7)
         m_regs[wa] = 32'(data_in);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic issue(input logic [31:0] ins);
      instr = ins;
      instr_valid = 1'b1;
      model_exec(ins);
      @(posedge clk);
      #10;
      instr_valid = 1'b0;
   endtask

   task automatic hold_invalid(input logic [31:0] ins);
      instr = ins;
      instr_valid = 1'b0;
      @(posedge clk);
      #10;
   endtask

   task automatic idle(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         #10;
      end
   endtask

   task automatic check_out(input string name);
      idle(3);   // fixed pipeline latency
      check(name, 32'(data_out), 32'(m_out));
   endtask

   // all 32 bits of r seen through data_out, 10 bits at a time via r63
   task automatic check_reg(input logic [5:0] r);
      for (int k = 0; k < 4; k++) begin
         issue(encode_alu(op_shift, 4'(sh_lr), 6'd63, r, 1'b1, 6'(10 * k)));
         issue(encode_alu(op_out, f_snd, 6'd63, 6'd63, 1'b0, 6'd63));
         check_out($sformatf("data_out r%0d bits %0d up", r, 10 * k));
      end
   endtask

   task automatic load_word(input logic [5:0] r, input logic [31:0] v);
      issue(encode_lc(r, 1'b0, v[22:0]));
      issue(encode_lu(r, v[31:23]));
   endtask

   task automatic wait_reset(output logic ok);
      for (int i = 0; i < 20 && reset !== 1'b0; i++)
         @(posedge clk);
      ok = (reset === 1'b0);
      #10;
   endtask

   task automatic reset_test();
      check("data_out", 32'(data_out), 32'h0);
      issue(encode_alu(op_out, f_add, 6'd0, 6'd0, 1'b0, 6'd0));
      check_out("data_out");
   endtask

   task automatic alu_test();
      for (int f = 0; f < 16; f++) begin
         load_word(6'd1, $urandom);
         load_word(6'd2, $urandom);
         issue(encode_alu(op_out, 4'(f), 6'd3, 6'd1, 1'b0, 6'd2));
         check_out($sformatf("data_out func %0d", f));
         check_reg(6'd3);
      end
   endtask

   task automatic flag_test();
      logic [31:0] xs [4] = '{32'h7fffffff, 32'hffffffff, 32'h80000000, 32'h00000001};
      logic [31:0] ys [4] = '{32'h00000001, 32'h00000001, 32'h00000001, 32'h00000002};
      logic [3:0]  fs [4] = '{f_add, f_add, f_sub, f_add};
      for (int n = 0; n < 4; n++) begin
         load_word(6'd1, xs[n]);
         load_word(6'd2, ys[n]);
         issue(encode_alu(op_normal, fs[n], 6'd3, 6'd1, 1'b0, 6'd2));
         issue(encode_alu(op_out, f_carry, 6'd4, 6'd0, 1'b0, 6'd0));
         check_out("data_out carry");
         issue(encode_alu(op_out, f_overflow, 6'd4, 6'd0, 1'b0, 6'd0));
         check_out("data_out overflow");
         issue(encode_alu(op_out, f_add_carry, 6'd3, 6'd1, 1'b0, 6'd2));
         check_out("data_out add carry");
      end
   endtask

   task automatic shift_test();
      logic [31:0] v;
      for (int kind = 0; kind < 4; kind++) begin
         for (int n = 0; n < 4; n++) begin
            v = $urandom;
            load_word(6'd1, $urandom);
            load_word(6'd2, (n == 0) ? 32'd32 + $urandom_range(0, 31) : $urandom_range(0, 63));
            issue(encode_alu(op_shift, {v[1:0], 2'(kind)}, 6'd4, 6'd1, 1'b0, 6'd2));
            check_reg(6'd4);
         end
      end
   endtask

   task automatic back_to_back_test();
      logic [31:0] v;
      logic [31:0] u;
      for (int n = 0; n < 4; n++) begin
         v = $urandom;
         u = $urandom;
         issue(encode_lc(6'd5, v[31], v[22:0]));
         issue(encode_lu(6'd5, u[8:0]));   // w from the instruction just ahead
         issue(encode_alu(op_normal, f_add, 6'd6, 6'd5, 1'b0, 6'd5));
         issue(encode_alu(op_normal, f_xor, 6'd7, 6'd6, 1'b0, 6'd5));
         issue(encode_lu(6'd7, u[17:9]));
         issue(encode_alu(op_out, f_sub, 6'd8, 6'd7, 1'b0, 6'd6));
         check_out("data_out back to back");
         for (int r = 5; r <= 8; r++)
            check_reg(6'(r));
      end
   endtask

   task automatic in_dropped_test();
      logic [31:0] v;
      for (int n = 0; n < 4; n++) begin
         v = $urandom;
         data_in = v[`SILVER_IN_W-1:0];
         issue(encode_alu(op_in, 4'd0, 6'd9, 6'd0, 1'b0, 6'd0));
         check_reg(6'd9);
      end
      load_word(6'd10, $urandom);
      for (int op = 2; op <= 12; op++)
         if (op < 6 || op > 7)
            issue(encode_alu(6'(op), f_inc, 6'd10, 6'd10, 1'b0, 6'd10));
      hold_invalid(encode_alu(op_out, f_inc, 6'd10, 6'd10, 1'b0, 6'd10));
      check_out("data_out after dropped");
      check_reg(6'd10);
   endtask

   initial begin
      instr_valid = 1'b0;
      instr = '0;
      data_in = '0;
      checks = 0;
      errors = 0;
      m_carry = 1'b0;
      m_ovf = 1'b0;
      m_out = '0;
      for (int i = 0; i < 64; i++)
         m_regs[i] = '0;
      void'($urandom(32'he98079e8));
      wait_reset(reset_ok);
      if (!reset_ok) begin
         $display("reset was never released");
         errors++;
      end else begin
         reset_test();
         alu_test();
         flag_test();
         shift_test();
         back_to_back_test();
         in_dropped_test();
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
